/* logic/io_mux_pkg.sv */
package io_mux_pkg;

	// Pad counts for the user area
	localparam int BANK_PADS  = 19;
	localparam int TOTAL_PADS = 2 * BANK_PADS;

	// Peripheral counts per bank
	localparam int UARTS_PER_BANK = 2;
	localparam int PWMS_PER_BANK  = 8;
	localparam int PWMS_PER_GROUP = 4;

	// One bit per pad across both banks
	typedef logic [TOTAL_PADS-1:0] pad_vec_t;

	// One bit per pad inside a single bank
	typedef logic [BANK_PADS-1:0] bank_vec_t;

	// One bit per PWM channel of a bank
	typedef logic [PWMS_PER_BANK-1:0] pwm_vec_t;

	// Power-on blink phase
	typedef logic [1:0] blink_count_t;

	// Pin offsets inside a bank
	// First UART pair
	localparam int UART_A_RX = 0;
	localparam int UART_A_TX = 1;

	// Lower PWM group, channels 0 to 3
	localparam int PWM_LO_BASE = 2;

	// SPI port
	localparam int SPI_CLK  = 6;
	localparam int SPI_MOSI = 7;
	localparam int SPI_MISO = 8;
	localparam int SPI_CS   = 9;

	// Second UART pair
	localparam int UART_B_RX = 10;
	localparam int UART_B_TX = 11;

	// Upper PWM group, channels 4 to 7
	localparam int PWM_HI_BASE = 12;

	// Blink output, only used in bank 0
	localparam int BLINK_PAD = 16;

	// Pads 17 and 18 carry GPIO only

endpackage

/* logic/blink_controller.sv */
`timescale 1ns/1ps

module blink_controller #(
	parameter int BLINK_DIV_BITS = 26
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     claim,
	output io_mux_pkg::blink_count_t blink_count,
	output logic                     blink_enable
);
	import io_mux_pkg::*;

	// Free-running prescaler
	logic [BLINK_DIV_BITS-1:0] prescaler;
	logic                      prescaler_wrap;

	// Blink phase counter
	blink_count_t count_q;
	blink_count_t count_next;

	// Sticky flag, set once firmware owns the blink pad
	logic claimed_q;

	assign prescaler_wrap = &prescaler;

	always_ff @(posedge clk) begin
		if (rst) begin
			prescaler <= '0;
		end else begin
			prescaler <= prescaler + 1'b1;
		end
	end

	// Carry from the prescaler advances the phase, wraps 3 -> 0
	always_comb begin
		count_next = count_q;
		if (prescaler_wrap) begin
			count_next = count_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
		end else begin
			count_q <= count_next;
		end
	end

	// Once claimed, the pad stays with GPIO until the next reset
	always_ff @(posedge clk) begin
		if (rst) begin
			claimed_q <= 1'b0;
		end else if (claim) begin
			claimed_q <= 1'b1;
		end
	end

	assign blink_count  = count_q;
	assign blink_enable = ~claimed_q;

endmodule

/* logic/io_bank_mux.sv */
`timescale 1ns/1ps

module io_bank_mux #(
	parameter bit HAS_BLINK = 1'b0
) (
	// UART pairs
	input  logic [1:0]            uart_en,
	input  logic [1:0]            uart_tx,
	output logic [1:0]            uart_rx,

	// SPI port
	input  logic                  spi_en,
	input  logic                  spi_clk,
	input  logic                  spi_mosi,
	input  logic                  spi_cs,
	output logic                  spi_miso,

	// PWM channels
	input  io_mux_pkg::pwm_vec_t  pwm_en,
	input  io_mux_pkg::pwm_vec_t  pwm_out,

	// Power-on blink
	input  logic                  blink_enable,
	input  logic                  blink_level,

	// GPIO block
	input  io_mux_pkg::bank_vec_t gpio_output,
	input  io_mux_pkg::bank_vec_t gpio_oeb,
	output io_mux_pkg::bank_vec_t gpio_input,

	// Pads of this bank
	input  io_mux_pkg::bank_vec_t pad_in,
	output io_mux_pkg::bank_vec_t pad_out,
	output io_mux_pkg::bank_vec_t pad_oeb
);
	import io_mux_pkg::*;

	// Per-pad owner view, built from the enables
	bank_vec_t owned;
	bank_vec_t owner_out;
	bank_vec_t owner_oeb;

	// Blink override only exists in the bank that has the blink pad
	logic blink_active;

	// Pad of a PWM channel, lower group then upper group
	function automatic int pwm_pad(input int ch);
		int pad;
		if (ch < PWMS_PER_GROUP) begin
			pad = PWM_LO_BASE + ch;
		end else begin
			pad = PWM_HI_BASE + ch - PWMS_PER_GROUP;
		end
		return pad;
	endfunction

	// Receive pad of a UART pair
	function automatic int uart_rx_pad(input int idx);
		int pad;
		pad = (idx == 0) ? UART_A_RX : UART_B_RX;
		return pad;
	endfunction

	// Transmit pad of a UART pair
	function automatic int uart_tx_pad(input int idx);
		int pad;
		pad = (idx == 0) ? UART_A_TX : UART_B_TX;
		return pad;
	endfunction

	assign blink_active = HAS_BLINK ? blink_enable : 1'b0;

	always_comb begin
		owned     = '0;
		owner_out = '0;
		owner_oeb = '0;

		// UART pairs, rx is an input pad
		for (int u = 0; u < UARTS_PER_BANK; u++) begin
			if (uart_en[u]) begin
				owned[uart_rx_pad(u)]     = 1'b1;
				owner_oeb[uart_rx_pad(u)] = 1'b1;
				owned[uart_tx_pad(u)]     = 1'b1;
				owner_out[uart_tx_pad(u)] = uart_tx[u];
			end
		end

		// SPI takes all four pads at once
		if (spi_en) begin
			owned[SPI_CLK]      = 1'b1;
			owner_out[SPI_CLK]  = spi_clk;
			owned[SPI_MOSI]     = 1'b1;
			owner_out[SPI_MOSI] = spi_mosi;
			owned[SPI_MISO]     = 1'b1;
			owner_oeb[SPI_MISO] = 1'b1;
			owned[SPI_CS]       = 1'b1;
			owner_out[SPI_CS]   = spi_cs;
		end

		// PWM channels are outputs only
		for (int ch = 0; ch < PWMS_PER_BANK; ch++) begin
			if (pwm_en[ch]) begin
				owned[pwm_pad(ch)]     = 1'b1;
				owner_out[pwm_pad(ch)] = pwm_out[ch];
			end
		end

		// Blink pad has no peripheral, so no conflict here
		if (blink_active) begin
			owned[BLINK_PAD]     = 1'b1;
			owner_out[BLINK_PAD] = blink_level;
		end
	end

	// Owned pads ignore the GPIO drive
	always_comb begin
		for (int p = 0; p < BANK_PADS; p++) begin
			if (owned[p]) begin
				pad_out[p]    = owner_out[p];
				pad_oeb[p]    = owner_oeb[p];
				gpio_input[p] = 1'b0;
			end else begin
				pad_out[p]    = gpio_output[p];
				pad_oeb[p]    = gpio_oeb[p];
				gpio_input[p] = pad_in[p];
			end
		end
	end

	// Peripheral inputs read zero while disabled
	always_comb begin
		for (int u = 0; u < UARTS_PER_BANK; u++) begin
			uart_rx[u] = uart_en[u] ? pad_in[uart_rx_pad(u)] : 1'b0;
		end
	end

	assign spi_miso = spi_en ? pad_in[SPI_MISO] : 1'b0;

endmodule

/* logic/io_mux_top.sv */
`timescale 1ns/1ps

module io_mux_top #(
	parameter int BLINK_DIV_BITS = 26
) (
	input  logic                     clk,
	input  logic                     rst,

	// Peripheral enables
	input  logic [3:0]               uart_en,
	input  logic [1:0]               spi_en,
	input  logic [15:0]              pwm_en,

	// Peripheral drives
	input  logic [3:0]               uart_tx,
	input  logic [1:0]               spi_clk,
	input  logic [1:0]               spi_mosi,
	input  logic [1:0]               spi_cs,
	input  logic [15:0]              pwm_out,

	// Peripheral inputs
	output logic [3:0]               uart_rx,
	output logic [1:0]               spi_miso,

	// GPIO, bank 0
	input  io_mux_pkg::bank_vec_t    gpio0_output,
	input  io_mux_pkg::bank_vec_t    gpio0_oeb,
	output io_mux_pkg::bank_vec_t    gpio0_input,

	// GPIO, bank 1
	input  io_mux_pkg::bank_vec_t    gpio1_output,
	input  io_mux_pkg::bank_vec_t    gpio1_oeb,
	output io_mux_pkg::bank_vec_t    gpio1_input,

	// Pads
	input  io_mux_pkg::pad_vec_t     pad_in,
	output io_mux_pkg::pad_vec_t     pad_out,
	output io_mux_pkg::pad_vec_t     pad_oeb,

	output io_mux_pkg::blink_count_t blink_count
);
	import io_mux_pkg::*;

	logic      blink_enable;
	logic      blink_claim;
	bank_vec_t bank0_pad_out;
	bank_vec_t bank0_pad_oeb;
	bank_vec_t bank1_pad_out;
	bank_vec_t bank1_pad_oeb;

	// Firmware claims the blink pad by turning it into an output
	assign blink_claim = ~gpio0_oeb[BLINK_PAD];

	blink_controller #(
		.BLINK_DIV_BITS(BLINK_DIV_BITS)
	) i_blink (
		.clk         (clk),
		.rst         (rst),
		.claim       (blink_claim),
		.blink_count (blink_count),
		.blink_enable(blink_enable)
	);

	// Bank 0 gets the lower halves and the blink pad
	io_bank_mux #(
		.HAS_BLINK(1'b1)
	) i_bank0 (
		.uart_en     (uart_en[1:0]),
		.uart_tx     (uart_tx[1:0]),
		.uart_rx     (uart_rx[1:0]),
		.spi_en      (spi_en[0]),
		.spi_clk     (spi_clk[0]),
		.spi_mosi    (spi_mosi[0]),
		.spi_cs      (spi_cs[0]),
		.spi_miso    (spi_miso[0]),
		.pwm_en      (pwm_en[7:0]),
		.pwm_out     (pwm_out[7:0]),
		.blink_enable(blink_enable),
		.blink_level (blink_count[0]),
		.gpio_output (gpio0_output),
		.gpio_oeb    (gpio0_oeb),
		.gpio_input  (gpio0_input),
		.pad_in      (pad_in[BANK_PADS-1:0]),
		.pad_out     (bank0_pad_out),
		.pad_oeb     (bank0_pad_oeb)
	);

	// Bank 1, pad 16 of this bank stays plain GPIO
	io_bank_mux #(
		.HAS_BLINK(1'b0)
	) i_bank1 (
		.uart_en     (uart_en[3:2]),
		.uart_tx     (uart_tx[3:2]),
		.uart_rx     (uart_rx[3:2]),
		.spi_en      (spi_en[1]),
		.spi_clk     (spi_clk[1]),
		.spi_mosi    (spi_mosi[1]),
		.spi_cs      (spi_cs[1]),
		.spi_miso    (spi_miso[1]),
		.pwm_en      (pwm_en[15:8]),
		.pwm_out     (pwm_out[15:8]),
		.blink_enable(1'b0),
		.blink_level (1'b0),
		.gpio_output (gpio1_output),
		.gpio_oeb    (gpio1_oeb),
		.gpio_input  (gpio1_input),
		.pad_in      (pad_in[TOTAL_PADS-1:BANK_PADS]),
		.pad_out     (bank1_pad_out),
		.pad_oeb     (bank1_pad_oeb)
	);

	// Banks own disjoint pads, so they simply stack
	assign pad_out = {bank1_pad_out, bank0_pad_out};
	assign pad_oeb = {bank1_pad_oeb, bank0_pad_oeb};

endmodule

/* sim/io_mux_props.sv */
`timescale 1ns/1ps

module io_mux_props #(
	parameter int BLINK_DIV_BITS = 26
) (
	input logic                     clk,
	input logic                     rst,
	input io_mux_pkg::bank_vec_t    gpio0_output,
	input io_mux_pkg::bank_vec_t    gpio0_oeb,
	input io_mux_pkg::bank_vec_t    gpio0_input,
	input io_mux_pkg::bank_vec_t    gpio1_output,
	input io_mux_pkg::bank_vec_t    gpio1_oeb,
	input io_mux_pkg::bank_vec_t    gpio1_input,
	input io_mux_pkg::pad_vec_t     pad_in,
	input io_mux_pkg::pad_vec_t     pad_out,
	input io_mux_pkg::pad_vec_t     pad_oeb,
	input io_mux_pkg::blink_count_t blink_count
);
	import io_mux_pkg::*;

	// Bank 1 copy of the blink pad position
	localparam int BANK1_PAD16 = BANK_PADS + BLINK_PAD;

	// Clock cycles since reset, all ones on the last cycle of a blink step
	logic [BLINK_DIV_BITS-1:0] div_cycles;
	// Firmware has turned pad 16 of bank 0 into an output since reset
	logic                      claimed;
	int unsigned               failures = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			div_cycles <= '0;
			claimed    <= 1'b0;
		end else begin
			div_cycles <= div_cycles + 1'b1;
			if (!gpio0_oeb[BLINK_PAD]) begin
				claimed <= 1'b1;
			end
		end
	end

	count_after_reset: assert property (@(posedge clk) rst |=> blink_count == 2'd0)
	else begin
		$error("blink_count is not zero after reset");
		failures++;
	end

	// Phase holds between prescaler carries
	count_holds: assert property (@(posedge clk) disable iff (rst)
		!(&div_cycles) |=> $stable(blink_count))
	else begin
		$error("blink_count changed before its step was due");
		failures++;
	end

	// Two-bit compare, so 3 steps to 0
	count_steps: assert property (@(posedge clk) disable iff (rst)
		(&div_cycles) |=> blink_count == $past(blink_count) + 2'd1)
	else begin
		$error("blink_count did not advance by one at its step");
		failures++;
	end

	blink_on_pad: assert property (@(posedge clk) disable iff (rst)
		!claimed |-> pad_out[BLINK_PAD] == blink_count[0] && !pad_oeb[BLINK_PAD]
			&& !gpio0_input[BLINK_PAD])
	else begin
		$error("pad 16 does not carry the blink while unclaimed");
		failures++;
	end

	gpio_on_pad: assert property (@(posedge clk) disable iff (rst)
		claimed |-> pad_out[BLINK_PAD] == gpio0_output[BLINK_PAD]
			&& pad_oeb[BLINK_PAD] == gpio0_oeb[BLINK_PAD]
			&& gpio0_input[BLINK_PAD] == pad_in[BLINK_PAD])
	else begin
		$error("pad 16 does not follow GPIO after the claim");
		failures++;
	end

	bank1_pad16_gpio: assert property (@(posedge clk)
		pad_out[BANK1_PAD16] == gpio1_output[BLINK_PAD]
			&& pad_oeb[BANK1_PAD16] == gpio1_oeb[BLINK_PAD]
			&& gpio1_input[BLINK_PAD] == pad_in[BANK1_PAD16])
	else begin
		$error("pad 35 is not plain GPIO");
		failures++;
	end

endmodule

bind io_mux_top io_mux_props #(
	.BLINK_DIV_BITS(BLINK_DIV_BITS)
) i_props (.*);

/* sim/io_mux_tb.sv */
`timescale 1ns/1ps

module io_mux_tb;
	import io_mux_pkg::*;

	localparam int          CLK_PERIOD   = 100;
	localparam int          RESET_CYCLES = 3;
	localparam int          MAX_CYCLES   = 2000;
	localparam logic [31:0] SEED         = 32'h3a8886b8;

	// What the stimulus does with gpio0_oeb[16]
	localparam int PAD16_FREE  = 0;
	localparam int PAD16_HOLD  = 1;
	localparam int PAD16_CLAIM = 2;

	logic         clk;
	logic         rst;
	logic [3:0]   uart_en;
	logic [1:0]   spi_en;
	logic [15:0]  pwm_en;
	logic [3:0]   uart_tx;
	logic [1:0]   spi_clk;
	logic [1:0]   spi_mosi;
	logic [1:0]   spi_cs;
	logic [15:0]  pwm_out;
	logic [3:0]   uart_rx;
	logic [1:0]   spi_miso;
	bank_vec_t    gpio0_output;
	bank_vec_t    gpio0_oeb;
	bank_vec_t    gpio0_input;
	bank_vec_t    gpio1_output;
	bank_vec_t    gpio1_oeb;
	bank_vec_t    gpio1_input;
	pad_vec_t     pad_in;
	pad_vec_t     pad_out;
	pad_vec_t     pad_oeb;
	blink_count_t blink_count;

	// Pad 16 of bank 0 belongs to GPIO as of the last drive
	logic        claimed;
	logic        checking;
	int unsigned cycle_count = 0;

	io_mux_top #(
		.BLINK_DIV_BITS(4)
	) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run still going after %0d cycles", cycle_count);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input int idx, input logic exp,
		input logic got);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s[%0d] expected %0b, got %0b",
				$time, name, idx, exp, got);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// Expected pad mapping of one bank from the offset table
	task automatic check_bank(input int b);
		bank_vec_t g_out;
		bank_vec_t g_oeb;
		bank_vec_t g_in;
		string     g_name;
		int        base;
		int        ch;
		logic      own;
		logic      exp_out;
		logic      exp_oeb;
		logic      exp_gin;
		g_out  = (b == 0) ? gpio0_output : gpio1_output;
		g_oeb  = (b == 0) ? gpio0_oeb : gpio1_oeb;
		g_in   = (b == 0) ? gpio0_input : gpio1_input;
		g_name = (b == 0) ? "gpio0_input" : "gpio1_input";
		base   = b * BANK_PADS;
		for (int p = 0; p < BANK_PADS; p++) begin
			// Blink pad of bank 0 is left to the bound assertions until claimed
			if (b == 0 && p == BLINK_PAD && !claimed) begin
				continue;
			end
			ch = -1;
			if (p >= PWM_LO_BASE && p < PWM_LO_BASE + 4) begin
				ch = p - PWM_LO_BASE;
			end
			if (p >= PWM_HI_BASE && p < PWM_HI_BASE + 4) begin
				ch = p - PWM_HI_BASE + 4;
			end
			case (p)
				UART_A_RX, UART_A_TX: own = uart_en[2 * b];
				UART_B_RX, UART_B_TX: own = uart_en[2 * b + 1];
				SPI_CLK, SPI_MOSI, SPI_MISO, SPI_CS: own = spi_en[b];
				default: own = (ch >= 0) ? pwm_en[8 * b + ch] : 1'b0;
			endcase
			case (p)
				UART_A_TX: exp_out = uart_tx[2 * b];
				UART_B_TX: exp_out = uart_tx[2 * b + 1];
				SPI_CLK: exp_out = spi_clk[b];
				SPI_MOSI: exp_out = spi_mosi[b];
				SPI_CS: exp_out = spi_cs[b];
				default: exp_out = (ch >= 0) ? pwm_out[8 * b + ch] : 1'b0;
			endcase
			// Peripheral inputs float the pad
			exp_oeb = (p == UART_A_RX || p == UART_B_RX || p == SPI_MISO);
			exp_out = own ? exp_out : g_out[p];
			exp_oeb = own ? exp_oeb : g_oeb[p];
			exp_gin = own ? 1'b0 : pad_in[base + p];
			check_value("pad_out", base + p, exp_out, pad_out[base + p]);
			check_value("pad_oeb", base + p, exp_oeb, pad_oeb[base + p]);
			check_value(g_name, p, exp_gin, g_in[p]);
		end
		check_value("uart_rx", 2 * b, uart_en[2 * b] ? pad_in[base + UART_A_RX] : 1'b0,
			uart_rx[2 * b]);
		check_value("uart_rx", 2 * b + 1,
			uart_en[2 * b + 1] ? pad_in[base + UART_B_RX] : 1'b0, uart_rx[2 * b + 1]);
		check_value("spi_miso", b, spi_en[b] ? pad_in[base + SPI_MISO] : 1'b0, spi_miso[b]);
	endtask

	task automatic drive_inputs(input bit periph, input bit pwm, input int pad16_mode);
		gpio0_output = bank_vec_t'($urandom);
		gpio0_oeb    = bank_vec_t'($urandom);
		gpio1_output = bank_vec_t'($urandom);
		gpio1_oeb    = bank_vec_t'($urandom);
		pad_in       = pad_vec_t'({$urandom, $urandom});
		uart_en      = periph ? 4'($urandom) : 4'd0;
		spi_en       = periph ? 2'($urandom) : 2'd0;
		pwm_en       = pwm ? 16'($urandom) : 16'd0;
		uart_tx      = 4'($urandom);
		spi_clk      = 2'($urandom);
		spi_mosi     = 2'($urandom);
		spi_cs       = 2'($urandom);
		pwm_out      = 16'($urandom);
		if (pad16_mode == PAD16_HOLD) begin
			gpio0_oeb[BLINK_PAD] = 1'b1;
		end
		if (pad16_mode == PAD16_CLAIM) begin
			gpio0_oeb[BLINK_PAD] = 1'b0;
		end
		if (!gpio0_oeb[BLINK_PAD]) begin
			claimed = 1'b1;
		end
	endtask

	// Each falling edge checks the previous drive and then drives anew
	task automatic run_cycles(input int n, input bit periph, input bit pwm, input int mode);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			if (checking) begin
				check_bank(0);
				check_bank(1);
			end
			drive_inputs(periph, pwm, mode);
			checking = 1'b1;
		end
	endtask

	task automatic hold_reset();
		rst                  = 1'b1;
		claimed              = 1'b0;
		checking             = 1'b0;
		gpio0_oeb[BLINK_PAD] = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		uart_en      = '0;
		spi_en       = '0;
		pwm_en       = '0;
		uart_tx      = '0;
		spi_clk      = '0;
		spi_mosi     = '0;
		spi_cs       = '0;
		pwm_out      = '0;
		gpio0_output = '0;
		gpio0_oeb    = '1;
		gpio1_output = '0;
		gpio1_oeb    = '1;
		pad_in       = '0;
		hold_reset();

		// Power-on blink with every peripheral off
		run_cycles(256, 1'b0, 1'b0, PAD16_HOLD);
		run_cycles(1, 1'b0, 1'b0, PAD16_CLAIM);
		run_cycles(256, 1'b0, 1'b0, PAD16_FREE);
		// UART and SPI, then PWM on top
		run_cycles(384, 1'b1, 1'b0, PAD16_FREE);
		run_cycles(384, 1'b1, 1'b1, PAD16_FREE);

		// Phase must be away from zero so that the restart shows
		while (blink_count == 2'd0) begin
			run_cycles(1, 1'b1, 1'b1, PAD16_FREE);
		end

		// Blink must come back after a reset in the middle of traffic
		hold_reset();
		run_cycles(64, 1'b1, 1'b1, PAD16_HOLD);
		@(negedge clk);
		check_bank(0);
		check_bank(1);

		if (i_dut.i_props.failures != 0) begin
			$display("CHECKS FAILED");
			$fatal(1);
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

/* io_mux_top.f */
logic/io_mux_pkg.sv
logic/blink_controller.sv
logic/io_bank_mux.sv
logic/io_mux_top.sv
sim/io_mux_props.sv
sim/io_mux_tb.sv

/* Makefile */
# Verilator flow for the pad multiplexer
# Override any variable on the command line, e.g. make SEED=7

VERILATOR ?= verilator
TOP       ?= io_mux_tb
SEED      ?= 982025912
FILELIST  ?= io_mux_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Fails on a nonzero exit or on the fail message in the log
run: $(BIN)
	@./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module io_mux_top -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
